// File: Bender.yml
package:
  name: mmu

sources:
  - hw/mmu_pkg.sv
  - hw/mmu_tlb.sv
  - hw/mmu_map.sv
  - hw/mmu.sv
  - target: test
    files:
      - dv/tb_clk_gen.sv
      - dv/mmu_asserts.sv
      - dv/tb_mmu.sv

// File: dv/mmu_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module mmu_asserts
    import mmu_pkg::*;
(
    input logic                   clk_i,
    input logic                   rst_n_i,
    input logic                   req_i,
    input logic                   ack_i,
    input logic [TLB_ENTRIES-1:0] ihit_i,
    input logic [TLB_ENTRIES-1:0] dhit_i
);

    // overlapping entries make the lookup undefined.
    ihit_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0(ihit_i))
        else $error("instruction lookup matched more than one tlb entry");

    dhit_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0(dhit_i))
        else $error("data lookup matched more than one tlb entry");

    ack_rise: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(ack_i) |-> $past(req_i))
        else $error("tlb write ack rose without a request");

    ack_fall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $fell(ack_i) |-> !$past(req_i))
        else $error("tlb write ack fell while the request was still high");

    ack_reset: assert property (@(posedge clk_i)
        !rst_n_i |=> !ack_i)
        else $error("tlb write ack high after a reset edge");

endmodule

bind mmu_tlb mmu_asserts asserts_i (
    .clk_i   (clk),
    .rst_n_i (rst_n_i),
    .req_i   (tlbw_req_i),
    .ack_i   (tlbw_ack_o),
    .ihit_i  (ihit),
    .dhit_i  (dhit)
);

`default_nettype wire

// File: dv/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk_o
);

    // 100 ns period.
    initial begin
        clk_o = 1'b0;
        forever begin
            #50 clk_o = ~clk_o;
        end
    end

endmodule

`default_nettype wire

// File: dv/tb_mmu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mmu
    import mmu_pkg::*;
();

    logic              clk;
    logic              rst_n;
    xlat_req_t         ireq;
    xlat_req_t         dreq;
    xlat_rsp_t         irsp;
    xlat_rsp_t         drsp;
    logic              user_mode;
    logic [ASID_W-1:0] asid;
    logic              kseg0_uc;
    tlbw_req_t         tlbw;
    logic              tlbw_req;
    logic              tlbw_ack;

    logic [15:0]       lfsr_q;
    tlb_entry_t        mirror [TLB_ENTRIES];
    xlat_rsp_t         exp_i;
    xlat_rsp_t         exp_d;
    logic              exp_ack;
    int                errors = 0;
    int                checks = 0;
    int                n_hit = 0;
    int                n_inv = 0;
    int                n_refill = 0;
    int                n_adel = 0;
    tlbw_req_t         wr_list [6];
    int                wr_gap [6];

    tb_clk_gen clk_gen (.clk_o(clk));

    mmu mmu_i (
        .clk              (clk),
        .rst_n_i          (rst_n),
        .ireq_i           (ireq),
        .irsp_o           (irsp),
        .dreq_i           (dreq),
        .drsp_o           (drsp),
        .user_mode_i      (user_mode),
        .asid_i           (asid),
        .kseg0_uncached_i (kseg0_uc),
        .tlbw_i           (tlbw),
        .tlbw_req_i       (tlbw_req),
        .tlbw_ack_o       (tlbw_ack)
    );

    // x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_q = lfsr_next(lfsr_q);
            r      = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    task automatic check_val(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s expected %h actual %h at %0t", name, expected, actual, $time);
        end
    endtask

    // reference translation, from the segment and tlb rules.
    function automatic xlat_rsp_t model_xlat(input xlat_req_t r);
        xlat_rsp_t   e;
        logic [31:0] va;
        logic        hit;
        logic        v;
        logic        c;
        logic [19:0] pfn;
        e       = '0;
        va      = r.vaddr;
        hit     = 1'b0;
        v       = 1'b0;
        c       = 1'b0;
        pfn     = '0;
        e.valid = r.en;
        if (user_mode && va[31]) begin
            e.adel = 1'b1;
        end else if (va[31:30] == 2'b10) begin
            e.paddr    = {3'b000, va[28:0]};
            e.uncached = va[29] || kseg0_uc;
        end else begin
            for (int k = 0; k < TLB_ENTRIES; k++) begin
                if (mirror[k].vpn2 == va[31:13] &&
                    (mirror[k].g || mirror[k].asid == asid) &&
                    (mirror[k].v0 || mirror[k].v1)) begin
                    hit = 1'b1;
                    pfn = va[12] ? mirror[k].pfn1 : mirror[k].pfn0;
                    v   = va[12] ? mirror[k].v1 : mirror[k].v0;
                    c   = va[12] ? mirror[k].c1 : mirror[k].c0;
                end
            end
            e.mapped   = 1'b1;
            e.uncached = !c;
            if (!hit) begin
                e.refill = 1'b1;
            end else if (!v) begin
                e.tlb_inv = 1'b1;
            end else begin
                e.paddr = {pfn, va[11:0]};
            end
        end
        return e;
    endfunction

    task automatic compare_rsp(input string name, input xlat_rsp_t e, input xlat_rsp_t a);
        if (e.valid) begin
            check_val(name, e, a);
        end else begin
            check_val({name, ".valid"}, e.valid, a.valid);
        end
    endtask

    task automatic tally(input xlat_rsp_t e);
        if (e.valid) begin
            if (e.adel) begin
                n_adel++;
            end else if (e.refill) begin
                n_refill++;
            end else if (e.tlb_inv) begin
                n_inv++;
            end else if (e.mapped) begin
                n_hit++;
            end
        end
    endtask

    // outputs are compared away from the rising edge.
    always @(negedge clk) begin
        if (rst_n !== 1'b1) begin
            exp_i   = '0;
            exp_d   = '0;
            exp_ack = 1'b0;
            for (int k = 0; k < TLB_ENTRIES; k++) begin
                mirror[k] = '0;
            end
        end else begin
            compare_rsp("irsp_o", exp_i, irsp);
            compare_rsp("drsp_o", exp_d, drsp);
            check_val("tlbw_ack_o", exp_ack, tlbw_ack);
            exp_i = model_xlat(ireq);
            exp_d = model_xlat(dreq);
            tally(exp_i);
            tally(exp_d);
            // a write lands at the next edge, after that edge's lookups.
            if (tlbw_req && !exp_ack) begin
                mirror[tlbw.idx] = tlbw.entry;
            end
            exp_ack = tlbw_req;
        end
    end

    task automatic drive_req(input xlat_req_t i, input xlat_req_t d, input logic um,
                             input logic k0, input logic [ASID_W-1:0] a);
        @(posedge clk);
        ireq      <= i;
        dreq      <= d;
        user_mode <= um;
        kseg0_uc  <= k0;
        asid      <= a;
    endtask

    // kind 0 unmapped kernel segment, 1 a page held in the tlb, else any.
    function automatic xlat_req_t rand_req(input int kind);
        xlat_req_t   r;
        logic [31:0] va;
        tlb_entry_t  t;
        va = rand_bits(32);
        if (kind == 0) begin
            va[31:30] = 2'b10;
        end else if (kind == 1) begin
            t         = mirror[rand_bits(3)];
            va[31:13] = t.vpn2;
        end
        r.en    = 1'b1;
        r.vaddr = va;
        return r;
    endfunction

    function automatic tlbw_req_t rand_write(input logic [TLB_IDX_W-1:0] idx,
                                             input logic [ASID_W-1:0] cur_asid);
        tlbw_req_t   w;
        logic        hi;
        logic        lo;
        logic [13:0] mid;
        hi  = rand_bits(1);
        lo  = rand_bits(1);
        mid = rand_bits(14);
        w.idx = idx;
        // index in the low vpn2 bits keeps entries apart.
        w.entry.vpn2 = {hi, hi | lo, mid, idx};
        w.entry.asid = rand_bits(1) ? cur_asid : rand_bits(8);
        w.entry.g    = (rand_bits(2) == 0);
        w.entry.pfn0 = rand_bits(20);
        w.entry.v0   = (rand_bits(2) != 0);
        w.entry.c0   = rand_bits(1);
        w.entry.pfn1 = rand_bits(20);
        w.entry.v1   = (rand_bits(2) != 0);
        w.entry.c1   = rand_bits(1);
        return w;
    endfunction

    task automatic wait_ack(input logic level);
        int n;
        n = 0;
        @(negedge clk);
        while (tlbw_ack !== level && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (tlbw_ack !== level) begin
            errors++;
            $display("tlb write handshake stalled, ack did not reach %0d in 20 cycles", level);
        end
    endtask

    task automatic tlb_write(input tlbw_req_t w);
        @(posedge clk);
        tlbw     <= w;
        tlbw_req <= 1'b1;
        wait_ack(1'b1);
        @(posedge clk);
        tlbw_req <= 1'b0;
        wait_ack(1'b0);
    endtask

    initial begin
        tlbw_req_t         w;
        xlat_req_t         ri;
        xlat_req_t         rd;
        logic [ASID_W-1:0] a;
        logic [ASID_W-1:0] base_asid;
        lfsr_q    = 16'd49;
        base_asid = 8'h3c;
        rst_n     = 1'b0;
        ireq      = '0;
        dreq      = '0;
        user_mode = 1'b0;
        asid      = '0;
        kseg0_uc  = 1'b0;
        tlbw      = '0;
        tlbw_req  = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        // kseg0 and kseg1 in kernel mode.
        repeat (40) begin
            drive_req(rand_req(0), rand_req(0), 1'b0, rand_bits(1), 8'h00);
        end

        // user mode above kuseg.
        repeat (20) begin
            ri = rand_req(2);
            rd = rand_req(2);
            ri.vaddr.seg.seg[2] = 1'b1;
            rd.vaddr.seg.seg[2] = 1'b1;
            drive_req(ri, rd, 1'b1, 1'b0, 8'h00);
        end

        // empty tlb, kseg2 and kuseg in kernel mode.
        repeat (20) begin
            ri = rand_req(2);
            rd = rand_req(2);
            ri.vaddr.seg.seg    = 3'b110;
            rd.vaddr.seg.seg[2] = 1'b0;
            drive_req(ri, rd, 1'b0, 1'b0, 8'h00);
        end

        drive_req('0, '0, 1'b0, 1'b0, base_asid);
        for (int k = 0; k < TLB_ENTRIES; k++) begin
            tlb_write(rand_write(k, base_asid));
        end

        // hits, with an occasional foreign asid.
        repeat (60) begin
            a = (rand_bits(2) == 0) ? rand_bits(8) : base_asid;
            drive_req(rand_req(1), rand_req(1), 1'b0, 1'b0, a);
        end

        // valid even page, invalid odd page.
        w          = rand_write(3'd5, base_asid);
        w.entry.g  = 1'b1;
        w.entry.v0 = 1'b1;
        w.entry.v1 = 1'b0;
        tlb_write(w);
        ri.en                = 1'b1;
        ri.vaddr.page.vpn2   = w.entry.vpn2;
        ri.vaddr.page.odd    = 1'b1;
        ri.vaddr.page.pg_off = rand_bits(12);
        rd                   = ri;
        rd.vaddr.page.odd    = 1'b0;
        drive_req(ri, rd, 1'b0, 1'b0, base_asid);

        for (int k = 0; k < 6; k++) begin
            wr_list[k] = rand_write(rand_bits(3), base_asid);
            wr_gap[k]  = rand_bits(3);
        end

        // back-to-back requests while the tlb is rewritten.
        fork
            repeat (100) begin
                ri    = rand_req(rand_bits(2) % 3);
                ri.en = (rand_bits(3) != 0);
                rd    = rand_req(rand_bits(2) % 3);
                rd.en = (rand_bits(3) != 0);
                drive_req(ri, rd, rand_bits(3) == 0, rand_bits(1), base_asid);
            end
            for (int k = 0; k < 6; k++) begin
                repeat (wr_gap[k]) @(posedge clk);
                tlb_write(wr_list[k]);
            end
        join

        drive_req('0, '0, 1'b0, 1'b0, base_asid);
        repeat (3) @(negedge clk);

        if (n_hit == 0 || n_inv == 0 || n_refill == 0 || n_adel == 0) begin
            errors++;
            $display("some response kinds never occurred: hit %0d inv %0d refill %0d adel %0d",
                     n_hit, n_inv, n_refill, n_adel);
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/mmu.sv
`timescale 1ns/1ps
`default_nettype none

module mmu
    import mmu_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n_i,

    input  xlat_req_t         ireq_i,
    output xlat_rsp_t         irsp_o,

    input  xlat_req_t         dreq_i,
    output xlat_rsp_t         drsp_o,

    input  logic              user_mode_i,
    input  logic [ASID_W-1:0] asid_i,
    input  logic              kseg0_uncached_i,

    input  tlbw_req_t         tlbw_i,
    input  logic              tlbw_req_i,
    output logic              tlbw_ack_o
);

    vaddr_u    ilook_va;
    vaddr_u    dlook_va;
    tlb_look_t ilook;
    tlb_look_t dlook;

    mmu_map inst_map (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .req_i            (ireq_i),
        .user_mode_i      (user_mode_i),
        .kseg0_uncached_i (kseg0_uncached_i),
        .look_va_o        (ilook_va),
        .look_i           (ilook),
        .rsp_o            (irsp_o)
    );

    mmu_map data_map (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .req_i            (dreq_i),
        .user_mode_i      (user_mode_i),
        .kseg0_uncached_i (kseg0_uncached_i),
        .look_va_o        (dlook_va),
        .look_i           (dlook),
        .rsp_o            (drsp_o)
    );

    // one joint tlb, looked up by both ports.
    mmu_tlb tlb (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .asid_i     (asid_i),
        .tlbw_i     (tlbw_i),
        .tlbw_req_i (tlbw_req_i),
        .tlbw_ack_o (tlbw_ack_o),
        .ilook_va_i (ilook_va),
        .ilook_o    (ilook),
        .dlook_va_i (dlook_va),
        .dlook_o    (dlook)
    );

endmodule

`default_nettype wire

// File: hw/mmu_map.sv
`timescale 1ns/1ps
`default_nettype none

module mmu_map
    import mmu_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,

    input  xlat_req_t req_i,
    input  logic      user_mode_i,
    input  logic      kseg0_uncached_i,

    // shared tlb lookup.
    output vaddr_u    look_va_o,
    input  tlb_look_t look_i,

    output xlat_rsp_t rsp_o
);

    vaddr_u    va;
    logic      is_kseg0;
    logic      is_kseg1;
    logic      addr_err;
    xlat_rsp_t rsp_d;
    xlat_rsp_t rsp_q;

    assign va = req_i.vaddr;

    assign is_kseg0 = (va.seg.seg == SEG_KSEG0);
    assign is_kseg1 = (va.seg.seg == SEG_KSEG1);

    // user mode may only touch kuseg.
    assign addr_err = user_mode_i && va.seg.seg[2];

    // the tlb only needs the page pair and the half.
    always_comb begin
        look_va_o             = '0;
        look_va_o.page.vpn2   = va.page.vpn2;
        look_va_o.page.odd    = va.page.odd;
    end

    always_comb begin
        rsp_d       = '0;
        rsp_d.valid = req_i.en;
        if (addr_err) begin
            rsp_d.adel = 1'b1;
        end else if (is_kseg0 || is_kseg1) begin
            rsp_d.paddr    = {3'b000, va.seg.seg_off};
            rsp_d.uncached = is_kseg1 || kseg0_uncached_i;
        end else begin
            rsp_d.mapped   = 1'b1;
            rsp_d.uncached = !look_i.c;
            if (!look_i.hit) begin
                rsp_d.refill = 1'b1;
            end else if (!look_i.v) begin
                rsp_d.tlb_inv = 1'b1;
            end else begin
                rsp_d.paddr = {look_i.pfn, va.page.pg_off};
            end
        end
    end

    // fixed one cycle latency, no back-pressure.
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            rsp_q <= '0;
        end else begin
            rsp_q <= rsp_d;
        end
    end

    assign rsp_o = rsp_q;

endmodule

`default_nettype wire

// File: hw/mmu_pkg.sv
`default_nettype none

package mmu_pkg;

    localparam int TLB_ENTRIES = 8;
    localparam int TLB_IDX_W   = 3;
    localparam int ASID_W      = 8;
    localparam int PFN_W       = 20;
    localparam int VPN2_W      = 19;
    localparam int PG_OFF_W    = 12;

    // unmapped kernel segments, top three address bits.
    localparam logic [2:0] SEG_KSEG0 = 3'b100;
    localparam logic [2:0] SEG_KSEG1 = 3'b101;

    typedef struct packed {
        logic [2:0]  seg;
        logic [28:0] seg_off;
    } va_seg_t;

    // even/odd page pair, 4 KiB pages.
    typedef struct packed {
        logic [VPN2_W-1:0]   vpn2;
        logic                odd;
        logic [PG_OFF_W-1:0] pg_off;
    } va_page_t;

    typedef union packed {
        va_seg_t  seg;
        va_page_t page;
    } vaddr_u;

    typedef struct packed {
        logic [VPN2_W-1:0] vpn2;
        logic [ASID_W-1:0] asid;
        logic              g;
        logic [PFN_W-1:0]  pfn0;
        logic              v0;
        logic              c0;
        logic [PFN_W-1:0]  pfn1;
        logic              v1;
        logic              c1;
    } tlb_entry_t;

    typedef struct packed {
        logic [TLB_IDX_W-1:0] idx;
        tlb_entry_t           entry;
    } tlbw_req_t;

    typedef struct packed {
        logic   en;
        vaddr_u vaddr;
    } xlat_req_t;

    typedef struct packed {
        logic             hit;
        logic [PFN_W-1:0] pfn;
        logic             v;
        logic             c;
    } tlb_look_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] paddr;
        logic        uncached;
        logic        mapped;
        // exception flags.
        logic        adel;
        logic        refill;
        logic        tlb_inv;
    } xlat_rsp_t;

endpackage

`default_nettype wire

// File: hw/mmu_tlb.sv
`timescale 1ns/1ps
`default_nettype none

module mmu_tlb
    import mmu_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n_i,

    input  logic [ASID_W-1:0] asid_i,

    input  tlbw_req_t         tlbw_i,
    input  logic              tlbw_req_i,
    output logic              tlbw_ack_o,

    input  vaddr_u            ilook_va_i,
    output tlb_look_t         ilook_o,

    input  vaddr_u            dlook_va_i,
    output tlb_look_t         dlook_o
);

    tlb_entry_t             entries_q [TLB_ENTRIES];
    logic                   ack_q;
    logic                   wr_en;
    logic [TLB_ENTRIES-1:0] ihit;
    logic [TLB_ENTRIES-1:0] dhit;

    // write once per transfer, on req seen with ack still low.
    assign wr_en = tlbw_req_i && !ack_q;

    // ack follows req one edge later, both ways.
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= tlbw_req_i;
        end
    end

    assign tlbw_ack_o = ack_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < TLB_ENTRIES; i++) begin
                entries_q[i] <= '0;
            end
        end else if (wr_en) begin
            entries_q[tlbw_i.idx] <= tlbw_i.entry;
        end
    end

    // an entry with both pages invalid counts as empty.
    function automatic logic [TLB_ENTRIES-1:0] match_vec(input vaddr_u va);
        logic [TLB_ENTRIES-1:0] m;
        m = '0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            m[i] = (entries_q[i].vpn2 == va.page.vpn2) &&
                   (entries_q[i].g || (entries_q[i].asid == asid_i)) &&
                   (entries_q[i].v0 || entries_q[i].v1);
        end
        return m;
    endfunction

    // and-or select over the hit vector.
    function automatic tlb_look_t select_half(input logic [TLB_ENTRIES-1:0] m,
                                              input vaddr_u va);
        tlb_look_t r;
        r     = '0;
        r.hit = |m;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (m[i]) begin
                if (va.page.odd) begin
                    r.pfn = r.pfn | entries_q[i].pfn1;
                    r.v   = r.v | entries_q[i].v1;
                    r.c   = r.c | entries_q[i].c1;
                end else begin
                    r.pfn = r.pfn | entries_q[i].pfn0;
                    r.v   = r.v | entries_q[i].v0;
                    r.c   = r.c | entries_q[i].c0;
                end
            end
        end
        return r;
    endfunction

    // instruction port.
    always_comb begin
        ihit    = match_vec(ilook_va_i);
        ilook_o = select_half(ihit, ilook_va_i);
    end

    // data port.
    always_comb begin
        dhit    = match_vec(dlook_va_i);
        dlook_o = select_half(dhit, dlook_va_i);
    end

endmodule

`default_nettype wire

// File: verilog.f
hw/mmu_pkg.sv
hw/mmu_tlb.sv
hw/mmu_map.sv
hw/mmu.sv
dv/tb_clk_gen.sv
dv/mmu_asserts.sv
dv/tb_mmu.sv
